// ==== design/chest_pkg.sv ====
`default_nettype none

package chest_pkg;

    localparam int SAMPLE_W      = 32;
    localparam int FFT_LEN       = 256;
    localparam int NUM_IBAR      = 8;
    localparam int PILOT_SPACING = 4;
    localparam int NUM_PILOTS    = 64;
    // Gold sequence offset Nc
    localparam int GOLD_NC       = 1600;
    localparam int LFSR_N        = 31;

    // real part in [15:0], imaginary part in [31:16]
    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [9:0]          n_id_t;
    typedef logic [2:0]          ibar_t;
    // bit 1 carries c(2m), bit 0 carries c(2m+1)
    typedef logic [1:0]          dmrs_pair_t;
    typedef logic [5:0]          pilot_idx_t;
    typedef logic signed [8:0]   corr_t;
    typedef logic [7:0]          corr_mag_t;

    typedef enum logic [2:0] {
        GEN_IDLE,
        GEN_LOAD,
        GEN_SKIP,
        GEN_STORE,
        GEN_DONE
    } gen_state_e;

    typedef enum logic [1:0] {
        DET_WAIT,
        DET_ACCUM,
        DET_FLUSH
    } det_state_e;

    typedef enum logic [1:0] {
        SEL_IDLE,
        SEL_SCAN,
        SEL_REPORT
    } sel_state_e;

endpackage

`default_nettype wire

// ==== design/dmrs_hypothesis.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmrs_hypothesis #(
    parameter chest_pkg::ibar_t IBAR = '0
) (
    input  wire logic                                        clk_i,
    input  wire logic                                        reset_ni,
    input  wire chest_pkg::n_id_t                            n_id_i,
    input  wire logic                                        n_id_valid_i,
    input  wire logic                                        lfsr_load_i,
    input  wire logic                                        lfsr_step_i,
    input  wire logic                                        x1_bit_i,
    input  wire logic                                        store_i,
    input  wire logic [$clog2(2*chest_pkg::NUM_PILOTS)-1:0]  store_bit_idx_i,
    input  wire logic                                        clear_i,
    input  wire logic                                        acc_i,
    input  wire chest_pkg::pilot_idx_t                       pilot_idx_i,
    input  wire chest_pkg::dmrs_pair_t                       demod_i,
    input  wire chest_pkg::dmrs_pair_t                       demod_rot_i,
    output chest_pkg::corr_mag_t                             corr_mag_o
);

    logic [chest_pkg::LFSR_N-1:0] c_init_q;
    logic [chest_pkg::LFSR_N-1:0] x2_q;
    logic                         even_bit_q;
    chest_pkg::dmrs_pair_t        dmrs_q [chest_pkg::NUM_PILOTS];
    chest_pkg::dmrs_pair_t        ref_pair;
    chest_pkg::corr_t             sum_q;
    chest_pkg::corr_t             sum_rot_q;
    chest_pkg::corr_mag_t         mag;
    chest_pkg::corr_mag_t         mag_rot;

    function automatic logic [chest_pkg::LFSR_N-1:0] calc_c_init(chest_pkg::n_id_t n_id);
        logic [31:0] ibar_p1;
        logic [31:0] full;
        ibar_p1 = 32'(IBAR) + 32'd1;
        full    = ((ibar_p1 * (32'(n_id[9:2]) + 32'd1)) << 11) + (ibar_p1 << 6)
                  + 32'(n_id[1:0]);
        return full[chest_pkg::LFSR_N-1:0];
    endfunction

    // +1 per matching bit, -1 per differing bit
    function automatic chest_pkg::corr_t pair_score(chest_pkg::dmrs_pair_t ref_p,
                                                    chest_pkg::dmrs_pair_t rx_p);
        chest_pkg::corr_t score;
        score = (ref_p[1] == rx_p[1]) ? 9'sd1 : -9'sd1;
        score = score + ((ref_p[0] == rx_p[0]) ? 9'sd1 : -9'sd1);
        return score;
    endfunction

    function automatic chest_pkg::corr_mag_t corr_abs(chest_pkg::corr_t value);
        chest_pkg::corr_t pos;
        pos = (value < 0) ? -value : value;
        return pos[$bits(chest_pkg::corr_mag_t)-1:0];
    endfunction

    always_ff @(posedge clk_i) begin
        if (n_id_valid_i) begin
            c_init_q <= calc_c_init(n_id_i);
        end
        if (lfsr_load_i) begin
            x2_q <= c_init_q;
        end else if (lfsr_step_i) begin
            x2_q <= {x2_q[3] ^ x2_q[2] ^ x2_q[1] ^ x2_q[0], x2_q[chest_pkg::LFSR_N-1:1]};
        end
    end

    // hold c(2m) until c(2m+1) arrives, then write the whole pair
    always_ff @(posedge clk_i) begin
        if (store_i) begin
            if (!store_bit_idx_i[0]) begin
                even_bit_q <= x1_bit_i ^ x2_q[0];
            end else begin
                dmrs_q[store_bit_idx_i[$clog2(2*chest_pkg::NUM_PILOTS)-1:1]] <=
                    {even_bit_q, x1_bit_i ^ x2_q[0]};
            end
        end
    end

    assign ref_pair = dmrs_q[pilot_idx_i];

    always_ff @(posedge clk_i) begin
        if (!reset_ni || clear_i) begin
            sum_q     <= '0;
            sum_rot_q <= '0;
        end else if (acc_i) begin
            sum_q     <= sum_q + pair_score(ref_pair, demod_i);
            sum_rot_q <= sum_rot_q + pair_score(ref_pair, demod_rot_i);
        end
    end

    assign mag        = corr_abs(sum_q);
    assign mag_rot    = corr_abs(sum_rot_q);
    assign corr_mag_o = (mag_rot > mag) ? mag_rot : mag;

endmodule

`default_nettype wire

// ==== design/ibar_selector.sv ====
`timescale 1ns/1ps
`default_nettype none

module ibar_selector (
    input  wire logic                  clk_i,
    input  wire logic                  reset_ni,
    input  wire logic                  symbol_done_i,
    input  wire chest_pkg::corr_mag_t  corr_mag_i [chest_pkg::NUM_IBAR],
    output chest_pkg::ibar_t           ibar_o,
    output chest_pkg::corr_mag_t       peak_o,
    output logic                       ibar_valid_o
);

    chest_pkg::sel_state_e  state_q;
    chest_pkg::ibar_t       idx_q;
    chest_pkg::ibar_t       best_idx_q;
    chest_pkg::corr_mag_t   best_mag_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q    <= chest_pkg::SEL_IDLE;
            idx_q      <= '0;
            best_idx_q <= '0;
            best_mag_q <= '0;
        end else begin
            case (state_q)
                chest_pkg::SEL_IDLE: begin
                    if (symbol_done_i) begin
                        idx_q      <= '0;
                        best_idx_q <= '0;
                        best_mag_q <= '0;
                        state_q    <= chest_pkg::SEL_SCAN;
                    end
                end
                chest_pkg::SEL_SCAN: begin
                    // strictly greater, so ties stay with the lower index
                    if (corr_mag_i[idx_q] > best_mag_q) begin
                        best_idx_q <= idx_q;
                        best_mag_q <= corr_mag_i[idx_q];
                    end
                    idx_q <= idx_q + 1'b1;
                    if (idx_q == chest_pkg::ibar_t'(chest_pkg::NUM_IBAR - 1)) begin
                        state_q <= chest_pkg::SEL_REPORT;
                    end
                end
                default: begin
                    state_q <= chest_pkg::SEL_IDLE;
                end
            endcase
        end
    end

    assign ibar_o       = best_idx_q;
    assign peak_o       = best_mag_q;
    assign ibar_valid_o = (state_q == chest_pkg::SEL_REPORT);

endmodule

`default_nettype wire

// ==== design/pbch_dmrs_seq_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pbch_dmrs_seq_gen (
    input  wire logic                                        clk_i,
    input  wire logic                                        reset_ni,
    input  wire logic                                        n_id_valid_i,
    output logic                                             lfsr_load_o,
    output logic                                             lfsr_step_o,
    output logic                                             x1_bit_o,
    output logic                                             store_o,
    output logic [$clog2(2*chest_pkg::NUM_PILOTS)-1:0]       store_bit_idx_o,
    output logic                                             dmrs_ready_o
);

    chest_pkg::gen_state_e                   state_q;
    logic [$clog2(chest_pkg::GOLD_NC)-1:0]   cnt_q;
    logic [chest_pkg::LFSR_N-1:0]            x1_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= chest_pkg::GEN_IDLE;
            cnt_q   <= '0;
        end else if (n_id_valid_i) begin
            // a new cell ID restarts generation from any state
            state_q <= chest_pkg::GEN_LOAD;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                chest_pkg::GEN_LOAD: begin
                    state_q <= chest_pkg::GEN_SKIP;
                end
                chest_pkg::GEN_SKIP: begin
                    if (cnt_q == chest_pkg::GOLD_NC - 1) begin
                        cnt_q   <= '0;
                        state_q <= chest_pkg::GEN_STORE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                chest_pkg::GEN_STORE: begin
                    if (cnt_q == 2 * chest_pkg::NUM_PILOTS - 1) begin
                        state_q <= chest_pkg::GEN_DONE;
                    end
                    cnt_q <= cnt_q + 1'b1;
                end
                default: begin
                    state_q <= state_q;
                end
            endcase
        end
    end

    // x1 is common to every hypothesis, x1(0) = 1 and the rest zero
    always_ff @(posedge clk_i) begin
        if (state_q == chest_pkg::GEN_LOAD) begin
            x1_q <= {{(chest_pkg::LFSR_N-1){1'b0}}, 1'b1};
        end else if (lfsr_step_o) begin
            x1_q <= {x1_q[3] ^ x1_q[0], x1_q[chest_pkg::LFSR_N-1:1]};
        end
    end

    assign lfsr_load_o     = (state_q == chest_pkg::GEN_LOAD);
    assign lfsr_step_o     = (state_q == chest_pkg::GEN_SKIP) || (state_q == chest_pkg::GEN_STORE);
    assign store_o         = (state_q == chest_pkg::GEN_STORE);
    assign store_bit_idx_o = cnt_q[$clog2(2*chest_pkg::NUM_PILOTS)-1:0];
    assign x1_bit_o        = x1_q[0];
    assign dmrs_ready_o    = (state_q == chest_pkg::GEN_DONE);

endmodule

`default_nettype wire

// ==== design/pbch_ibar_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

module pbch_ibar_detector (
    input  wire logic                  clk_i,
    input  wire logic                  reset_ni,
    input  wire chest_pkg::n_id_t      n_id_i,
    input  wire logic                  n_id_valid_i,
    input  wire chest_pkg::sample_t    sample_i,
    input  wire logic                  sample_valid_i,
    input  wire logic                  pbch_start_i,
    output logic                       dmrs_ready_o,
    output chest_pkg::ibar_t           ibar_o,
    output chest_pkg::corr_mag_t       peak_o,
    output logic                       ibar_valid_o
);

    logic                                            lfsr_load;
    logic                                            lfsr_step;
    logic                                            x1_bit;
    logic                                            store;
    logic [$clog2(2*chest_pkg::NUM_PILOTS)-1:0]      store_bit_idx;
    logic                                            clear;
    logic                                            acc;
    chest_pkg::pilot_idx_t                           pilot_idx;
    chest_pkg::dmrs_pair_t                           demod;
    chest_pkg::dmrs_pair_t                           demod_rot;
    logic                                            symbol_done;
    chest_pkg::corr_mag_t                            corr_mag [chest_pkg::NUM_IBAR];

    pbch_dmrs_seq_gen u_seq_gen (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .n_id_valid_i    (n_id_valid_i),
        .lfsr_load_o     (lfsr_load),
        .lfsr_step_o     (lfsr_step),
        .x1_bit_o        (x1_bit),
        .store_o         (store),
        .store_bit_idx_o (store_bit_idx),
        .dmrs_ready_o    (dmrs_ready_o)
    );

    pbch_pilot_extractor u_extractor (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .dmrs_ready_i   (dmrs_ready_o),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .pbch_start_i   (pbch_start_i),
        .clear_o        (clear),
        .acc_o          (acc),
        .pilot_idx_o    (pilot_idx),
        .demod_o        (demod),
        .demod_rot_o    (demod_rot),
        .symbol_done_o  (symbol_done)
    );

    // one branch per ibar hypothesis
    for (genvar g = 0; g < chest_pkg::NUM_IBAR; g++) begin : g_hyp
        dmrs_hypothesis #(
            .IBAR (chest_pkg::ibar_t'(g))
        ) u_hyp (
            .clk_i           (clk_i),
            .reset_ni        (reset_ni),
            .n_id_i          (n_id_i),
            .n_id_valid_i    (n_id_valid_i),
            .lfsr_load_i     (lfsr_load),
            .lfsr_step_i     (lfsr_step),
            .x1_bit_i        (x1_bit),
            .store_i         (store),
            .store_bit_idx_i (store_bit_idx),
            .clear_i         (clear),
            .acc_i           (acc),
            .pilot_idx_i     (pilot_idx),
            .demod_i         (demod),
            .demod_rot_i     (demod_rot),
            .corr_mag_o      (corr_mag[g])
        );
    end

    ibar_selector u_selector (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .symbol_done_i (symbol_done),
        .corr_mag_i    (corr_mag),
        .ibar_o        (ibar_o),
        .peak_o        (peak_o),
        .ibar_valid_o  (ibar_valid_o)
    );

endmodule

`default_nettype wire

// ==== design/pbch_pilot_extractor.sv ====
`timescale 1ns/1ps
`default_nettype none

module pbch_pilot_extractor (
    input  wire logic                  clk_i,
    input  wire logic                  reset_ni,
    input  wire chest_pkg::n_id_t      n_id_i,
    input  wire logic                  n_id_valid_i,
    input  wire logic                  dmrs_ready_i,
    input  wire chest_pkg::sample_t    sample_i,
    input  wire logic                  sample_valid_i,
    input  wire logic                  pbch_start_i,
    output logic                       clear_o,
    output logic                       acc_o,
    output chest_pkg::pilot_idx_t      pilot_idx_o,
    output chest_pkg::dmrs_pair_t      demod_o,
    output chest_pkg::dmrs_pair_t      demod_rot_o,
    output logic                       symbol_done_o
);

    chest_pkg::det_state_e                    state_q;
    logic [$clog2(chest_pkg::FFT_LEN)-1:0]    sc_cnt_q;
    logic [$clog2(chest_pkg::FFT_LEN)-1:0]    sc_q;
    chest_pkg::pilot_idx_t                    pilot_cnt_q;
    chest_pkg::sample_t                       sample_q;
    logic [1:0]                               nu_q;
    logic                                     take_q;
    logic                                     last_pilot_q;
    logic                                     take;
    logic                                     sign_re;
    logic                                     sign_im;

    assign clear_o = (state_q == chest_pkg::DET_WAIT) && pbch_start_i && sample_valid_i
                     && dmrs_ready_i;
    assign take    = clear_o || ((state_q == chest_pkg::DET_ACCUM) && sample_valid_i);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q  <= chest_pkg::DET_WAIT;
            sc_cnt_q <= '0;
        end else begin
            case (state_q)
                chest_pkg::DET_WAIT: begin
                    if (clear_o) begin
                        // the start sample itself is subcarrier 0
                        sc_cnt_q <= 1;
                        state_q  <= chest_pkg::DET_ACCUM;
                    end
                end
                chest_pkg::DET_ACCUM: begin
                    if (sample_valid_i) begin
                        sc_cnt_q <= sc_cnt_q + 1'b1;
                        if (sc_cnt_q == chest_pkg::FFT_LEN - 1) begin
                            state_q <= chest_pkg::DET_FLUSH;
                        end
                    end
                end
                default: begin
                    // hold off a new start until the selector has read all magnitudes
                    if (sc_cnt_q == chest_pkg::NUM_IBAR + 2) begin
                        sc_cnt_q <= '0;
                        state_q  <= chest_pkg::DET_WAIT;
                    end else begin
                        sc_cnt_q <= sc_cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    // one register stage between the sample input and the pilot strobes
    always_ff @(posedge clk_i) begin
        sample_q <= sample_i;
        sc_q     <= sc_cnt_q;
        if (n_id_valid_i) begin
            nu_q <= n_id_i[1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            take_q        <= 1'b0;
            pilot_cnt_q   <= '0;
            last_pilot_q  <= 1'b0;
            symbol_done_o <= 1'b0;
        end else begin
            take_q        <= take;
            last_pilot_q  <= acc_o &&
                (pilot_cnt_q == chest_pkg::pilot_idx_t'(chest_pkg::NUM_PILOTS - 1));
            symbol_done_o <= last_pilot_q;
            if (clear_o) begin
                pilot_cnt_q <= '0;
            end else if (acc_o) begin
                pilot_cnt_q <= pilot_cnt_q + 1'b1;
            end
        end
    end

    assign acc_o       = take_q && (sc_q[$clog2(chest_pkg::PILOT_SPACING)-1:0] == nu_q);
    assign pilot_idx_o = pilot_cnt_q;

    // hard QPSK decision on the sign bits
    assign sign_re     = sample_q[chest_pkg::SAMPLE_W/2-1];
    assign sign_im     = sample_q[chest_pkg::SAMPLE_W-1];
    assign demod_o     = {sign_re, sign_im};
    assign demod_rot_o = {~sign_im, sign_re};

endmodule

`default_nettype wire

// ==== testbench/ibar_trace.txt ====
# n_id ibar rot flips early
# cell ID, transmitted ibar, 90-degree rotation, pilots with bit 1 flipped, start before ready
0 0 0 0 0
0 5 0 0 0
0 3 1 0 0
1 2 0 0 0
502 7 0 0 0
502 4 0 20 0
1007 6 1 0 0
1007 1 0 64 0
213 3 0 32 1
213 6 1 40 0

// ==== testbench/pbch_ibar_detector_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module pbch_ibar_detector_assert (
    input wire logic clk_i,
    input wire logic reset_ni,
    input wire logic n_id_valid_i,
    input wire logic dmrs_ready_o,
    input wire logic ibar_valid_o
);

    a_valid_single: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_o |=> !ibar_valid_o)
        else $error("ibar_valid_o held high for more than one cycle");

    a_ready_drops: assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_valid_i |=> !dmrs_ready_o)
        else $error("dmrs_ready_o high in the cycle after an n_id load");

    a_valid_needs_ready: assert property (@(posedge clk_i) disable iff (!reset_ni)
        $rose(ibar_valid_o) |-> dmrs_ready_o)
        else $error("ibar_valid_o rose while dmrs_ready_o was low");

    a_reset_outputs: assert property (@(posedge clk_i)
        !reset_ni |=> (!dmrs_ready_o && !ibar_valid_o))
        else $error("outputs not low after reset");

endmodule

bind pbch_ibar_detector pbch_ibar_detector_assert u_assert (
    .clk_i        (clk_i),
    .reset_ni     (reset_ni),
    .n_id_valid_i (n_id_valid_i),
    .dmrs_ready_o (dmrs_ready_o),
    .ibar_valid_o (ibar_valid_o)
);

`default_nettype wire

// ==== testbench/tb_dmrs_model.svh ====
`ifndef TB_DMRS_MODEL_SVH
`define TB_DMRS_MODEL_SVH

// Galois form of x^32 + x^22 + x^2 + x + 1, shifting right
function automatic logic [31:0] galois_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
endfunction

// bit n of the result is c(n) for n = 0..127, after the Nc offset
function automatic logic [127:0] gold_bits(input int n_id, input int ibar);
    logic     x1 [chest_pkg::GOLD_NC + 2*chest_pkg::NUM_PILOTS];
    logic     x2 [chest_pkg::GOLD_NC + 2*chest_pkg::NUM_PILOTS];
    int       c_init;
    int       n;
    logic [127:0] c;
    c_init = 2048 * (ibar + 1) * (n_id / 4 + 1) + 64 * (ibar + 1) + (n_id % 4);
    for (n = 0; n < chest_pkg::LFSR_N; n++) begin
        x1[n] = (n == 0);
        x2[n] = c_init[n];
    end
    for (n = 0; n + chest_pkg::LFSR_N < chest_pkg::GOLD_NC + 2*chest_pkg::NUM_PILOTS; n++) begin
        x1[n+31] = x1[n+3] ^ x1[n];
        x2[n+31] = x2[n+3] ^ x2[n+2] ^ x2[n+1] ^ x2[n];
    end
    for (n = 0; n < 2*chest_pkg::NUM_PILOTS; n++) begin
        c[n] = x1[n+chest_pkg::GOLD_NC] ^ x2[n+chest_pkg::GOLD_NC];
    end
    return c;
endfunction

// pilots carry the transmitted pairs, data subcarriers take random signs
function automatic logic [chest_pkg::FFT_LEN*chest_pkg::SAMPLE_W-1:0] build_symbol(
    input int nu, input logic [127:0] tx_bits, input logic rot, input int flips,
    inout logic [31:0] rng);
    logic [chest_pkg::FFT_LEN*chest_pkg::SAMPLE_W-1:0] sym;
    logic signed [15:0] re;
    logic signed [15:0] im;
    logic signed [15:0] tmp;
    logic               p1;
    logic               p0;
    int                 k;
    for (k = 0; k < chest_pkg::FFT_LEN; k++) begin
        if (k % chest_pkg::PILOT_SPACING == nu) begin
            p1 = tx_bits[2*(k/4)];
            p0 = tx_bits[2*(k/4)+1];
            if (k / 4 < flips) begin
                p1 = ~p1;
            end
        end else begin
            rng = galois_step(rng);
            p1  = rng[0];
            rng = galois_step(rng);
            p0  = rng[0];
        end
        re = p1 ? -16'sd1000 : 16'sd1000;
        im = p0 ? -16'sd1000 : 16'sd1000;
        // multiply by j
        if (rot) begin
            tmp = re;
            re  = -im;
            im  = tmp;
        end
        sym[k*chest_pkg::SAMPLE_W +: chest_pkg::SAMPLE_W] = {im, re};
    end
    return sym;
endfunction

// larger of the straight and rotated correlation magnitudes
function automatic int corr_magnitude(
    input logic [chest_pkg::FFT_LEN*chest_pkg::SAMPLE_W-1:0] sym,
    input int nu, input logic [127:0] ref_c);
    logic [31:0] smp;
    int          s;
    int          sr;
    int          k;
    int          m;
    s  = 0;
    sr = 0;
    for (k = 0; k < chest_pkg::FFT_LEN; k++) begin
        if (k % chest_pkg::PILOT_SPACING == nu) begin
            m   = k / 4;
            smp = sym[k*chest_pkg::SAMPLE_W +: chest_pkg::SAMPLE_W];
            s   = s + ((smp[15] == ref_c[2*m]) ? 1 : -1);
            s   = s + ((smp[31] == ref_c[2*m+1]) ? 1 : -1);
            sr  = sr + ((~smp[31] == ref_c[2*m]) ? 1 : -1);
            sr  = sr + ((smp[15] == ref_c[2*m+1]) ? 1 : -1);
        end
    end
    s  = (s < 0) ? -s : s;
    sr = (sr < 0) ? -sr : sr;
    return (sr > s) ? sr : s;
endfunction

`endif

// ==== testbench/tb_pbch_ibar_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pbch_ibar_detector;

    logic                  clk_i;
    logic                  reset_ni;
    chest_pkg::n_id_t      n_id_i;
    logic                  n_id_valid_i;
    chest_pkg::sample_t    sample_i;
    logic                  sample_valid_i;
    logic                  pbch_start_i;
    logic                  dmrs_ready_o;
    chest_pkg::ibar_t      ibar_o;
    chest_pkg::corr_mag_t  peak_o;
    logic                  ibar_valid_o;

    // one entry per trace line
    int t_n_id[$];
    int t_ibar[$];
    int t_rot[$];
    int t_flips[$];
    int t_early[$];

    int                    num_tests;
    int                    test_idx;
    int                    prev_n_id;
    int                    valid_count = 0;
    logic                  tests_loaded;
    logic [31:0]           rng_state;
    logic [127:0]          ref_bits [chest_pkg::NUM_IBAR];
    logic [chest_pkg::FFT_LEN*chest_pkg::SAMPLE_W-1:0] symbol;
    chest_pkg::ibar_t      exp_ibar;
    chest_pkg::ibar_t      got_ibar;
    chest_pkg::corr_mag_t  exp_peak;
    chest_pkg::corr_mag_t  got_peak;

    `include "tb_dmrs_model.svh"

    pbch_ibar_detector dut (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .pbch_start_i   (pbch_start_i),
        .dmrs_ready_o   (dmrs_ready_o),
        .ibar_o         (ibar_o),
        .peak_o         (peak_o),
        .ibar_valid_o   (ibar_valid_o)
    );

    // 100 ns period
    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        if (reset_ni && ibar_valid_o) begin
            valid_count <= valid_count + 1;
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_ibar(input chest_pkg::ibar_t actual, input chest_pkg::ibar_t expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("MISMATCH at %0t ns: test %0d ibar_o is %0d, expected %0d",
                                      $time, test_idx, actual, expected));
        end
    endtask

    task automatic check_peak(input chest_pkg::corr_mag_t actual,
                              input chest_pkg::corr_mag_t expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("MISMATCH at %0t ns: test %0d peak_o is %0d, expected %0d",
                                      $time, test_idx, actual, expected));
        end
    endtask

    task automatic read_trace();
        int    fd;
        int    code;
        int    cols [5];
        string line;
        fd = $fopen("testbench/ibar_trace.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open the trace file testbench/ibar_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                // lines starting with # describe the columns
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%d %d %d %d %d", cols[0], cols[1], cols[2], cols[3],
                                cols[4]) == 5) begin
                        t_n_id.push_back(cols[0]);
                        t_ibar.push_back(cols[1]);
                        t_rot.push_back(cols[2]);
                        t_flips.push_back(cols[3]);
                        t_early.push_back(cols[4]);
                    end
                end
            end
            $fclose(fd);
            num_tests = t_n_id.size();
        end
    endtask

    task automatic load_n_id(input int value);
        int h;
        n_id_i       = chest_pkg::n_id_t'(value);
        n_id_valid_i = 1'b1;
        @(negedge clk_i);
        n_id_valid_i = 1'b0;
        for (h = 0; h < chest_pkg::NUM_IBAR; h++) begin
            ref_bits[h] = gold_bits(value, h);
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!dmrs_ready_o && cycles < 2500) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!dmrs_ready_o) begin
            stop_with_error("dmrs_ready_o did not rise after the n_id load");
        end
    endtask

    // one idle cycle after every 37 samples
    task automatic send_symbol();
        int k;
        for (k = 0; k < chest_pkg::FFT_LEN; k++) begin
            if (k != 0 && k % 37 == 0) begin
                sample_valid_i = 1'b0;
                pbch_start_i   = 1'b0;
                @(negedge clk_i);
            end
            sample_i       = symbol[k*chest_pkg::SAMPLE_W +: chest_pkg::SAMPLE_W];
            sample_valid_i = 1'b1;
            pbch_start_i   = (k == 0);
            @(negedge clk_i);
        end
        sample_valid_i = 1'b0;
        pbch_start_i   = 1'b0;
    endtask

    task automatic compute_expected(input int nu);
        int h;
        int mag;
        int best;
        best     = 0;
        exp_ibar = '0;
        for (h = 0; h < chest_pkg::NUM_IBAR; h++) begin
            mag = corr_magnitude(symbol, nu, ref_bits[h]);
            if (mag > best) begin
                best     = mag;
                exp_ibar = chest_pkg::ibar_t'(h);
            end
        end
        exp_peak = chest_pkg::corr_mag_t'(best);
    endtask

    task automatic await_result();
        int   i;
        logic got;
        got = 1'b0;
        for (i = 0; i < 20 && !got; i++) begin
            @(negedge clk_i);
            if (ibar_valid_o) begin
                got      = 1'b1;
                got_ibar = ibar_o;
                got_peak = peak_o;
            end
        end
        if (!got) begin
            stop_with_error("no ibar_valid_o pulse within 20 cycles after the last subcarrier");
        end
    endtask

    task automatic run_test(input int idx);
        int count_before;
        if (t_n_id[idx] != prev_n_id || t_early[idx] != 0) begin
            load_n_id(t_n_id[idx]);
            prev_n_id = t_n_id[idx];
        end
        symbol = build_symbol(t_n_id[idx] % 4, ref_bits[t_ibar[idx]], t_rot[idx] != 0,
                              t_flips[idx], rng_state);
        compute_expected(t_n_id[idx] % 4);
        if (t_early[idx] != 0) begin
            if (dmrs_ready_o) begin
                stop_with_error("dmrs_ready_o was already high when the early start was sent");
            end
            count_before = valid_count;
            send_symbol();
            repeat (20) @(negedge clk_i);
            if (valid_count != count_before) begin
                stop_with_error("ibar_valid_o pulsed for a start sent before dmrs_ready_o");
            end
        end
        wait_ready();
        count_before = valid_count;
        send_symbol();
        await_result();
        check_ibar(got_ibar, exp_ibar);
        check_peak(got_peak, exp_peak);
        repeat (5) @(negedge clk_i);
        if (valid_count != count_before + 1) begin
            stop_with_error("ibar_valid_o pulsed more than once for one symbol");
        end
    endtask

    initial begin
        clk_i          = 1'b0;
        reset_ni       = 1'b0;
        n_id_i         = '0;
        n_id_valid_i   = 1'b0;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        pbch_start_i   = 1'b0;
        rng_state      = 32'hcfcac503;
        tests_loaded   = 1'b0;
        prev_n_id      = -1;
        read_trace();
        tests_loaded = 1'b1;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        reset_ni = 1'b1;
        if (dmrs_ready_o !== 1'b0 || ibar_valid_o !== 1'b0) begin
            stop_with_error("dmrs_ready_o or ibar_valid_o is not low after reset");
        end
        for (test_idx = 0; test_idx < num_tests; test_idx++) begin
            run_test(test_idx);
        end
        @(negedge clk_i);
        if (valid_count != num_tests) begin
            stop_with_error("the number of result pulses differs from the number of symbols");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

    // watchdog sized from the number of trace lines
    initial begin
        wait (tests_loaded);
        repeat (num_tests * 2500 + 100) @(posedge clk_i);
        stop_with_error("watchdog timeout, the run did not finish in time");
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+testbench
design/chest_pkg.sv
design/pbch_dmrs_seq_gen.sv
design/dmrs_hypothesis.sv
design/pbch_pilot_extractor.sv
design/ibar_selector.sv
design/pbch_ibar_detector.sv
testbench/pbch_ibar_detector_assert.sv
testbench/tb_pbch_ibar_detector.sv
